// ==== logic/board_pkg.sv ====
package board_pkg;

    // board selector, one code per supported pcb
    typedef enum logic [2:0] {
        GAME_OTHER    = 3'd0,       // catch-all, default flags and empty map
        GAME_FINALB   = 3'd1,
        GAME_DINOREX  = 3'd2,
        GAME_LIQUIDK  = 3'd3,
        GAME_GUNFRONT = 3'd4,
        GAME_GROWL    = 3'd5,
        GAME_DONDOKOD = 3'd6
    } game_t;

    // cpu memory regions decoded by the board
    typedef enum logic [3:0] {
        REGION_ROM       = 4'd0,    // main program rom
        REGION_ROM1      = 4'd1,    // second program rom bank
        REGION_WORK_RAM  = 4'd2,
        REGION_SCREEN    = 4'd3,    // tilemap chip ram
        REGION_OBJ       = 4'd4,    // sprite ram
        REGION_COLOR     = 4'd5,    // palette ram or pcr
        REGION_IO        = 4'd6,    // dsw, coin, inputs
        REGION_SOUND     = 4'd7,    // sound comms latch
        REGION_EXTENSION = 4'd8,    // object extender / bank regs
        REGION_PRIORITY  = 4'd9,    // priority mixer regs
        REGION_ROZ       = 4'd10    // rotation/zoom layer ram
    } region_t;

    localparam int NUM_REGIONS = 11;    // entries in region_t

    // window word: base is addr[23:16], low byte is decode mask
    typedef logic [15:0] window_t;

    // object extender mode
    typedef logic [1:0] obj_ext_t;

    localparam window_t WINDOW_UNUSED = 16'hff00;   // base ff, mask 00, never decodes

    localparam obj_ext_t OBJ_EXT_NONE = 2'd0;       // plain sprite path
    localparam obj_ext_t OBJ_EXT_DINO = 2'd1;       // extender layout used by dinorex

endpackage

// ==== logic/board_feature_flags.sv ====
module board_feature_flags (
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::game_t    game,        // board select, sampled each edge

    output logic                has_360pri,  // priority mixer fitted
    output logic                has_260dar,  // palette controller fitted
    output logic                has_110pcr,  // older palette chip instead
    output logic                io_swap,     // swapped io port layout
    output logic                io_tmp,      // growl style io decode
    output logic                has_190fmc,  // extra sprite bank chip
    output board_pkg::obj_ext_t obj_ext      // object extender mode
);

    import board_pkg::*;

    // one cycle from game to flags
    always_ff @(posedge clk) begin
        if (rst) begin
            has_360pri <= 1'b0;
            has_260dar <= 1'b0;
            has_110pcr <= 1'b0;
            io_swap    <= 1'b0;
            io_tmp     <= 1'b0;
            has_190fmc <= 1'b0;
            obj_ext    <= OBJ_EXT_NONE;
        end else begin
            // default row, covers liquidk, dondokod and other
            has_360pri <= 1'b1;
            has_260dar <= 1'b1;
            has_110pcr <= 1'b0;
            io_swap    <= 1'b0;
            io_tmp     <= 1'b0;
            has_190fmc <= 1'b0;
            obj_ext    <= OBJ_EXT_NONE;

            case (game)
                GAME_FINALB: begin           // early board, pcr only
                    has_360pri <= 1'b0;
                    has_260dar <= 1'b0;
                    has_110pcr <= 1'b1;
                end
                GAME_DINOREX: begin
                    obj_ext <= OBJ_EXT_DINO; // big sprite extender
                end
                GAME_GUNFRONT: begin
                    io_swap <= 1'b1;         // player ports swapped
                end
                GAME_GROWL: begin
                    io_tmp     <= 1'b1;      // split io decode
                    has_190fmc <= 1'b1;      // sprite bank chip
                end
                default: begin
                end
            endcase
        end
    end

    // the two palette paths are exclusive on every board
    a_palette_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(has_360pri && has_110pcr)
    ) else $error("360pri and 110pcr both set");

    // split io decode only comes with the bank chip
    a_tmp_needs_fmc: assert property (
        @(posedge clk) disable iff (rst)
        io_tmp |-> has_190fmc
    ) else $error("io_tmp without has_190fmc");

endmodule

// ==== logic/board_memory_map.sv ====
module board_memory_map (
    input  logic               clk,
    input  logic               rst,
    input  board_pkg::game_t   game,            // board select, sampled each edge

    output board_pkg::window_t addr_rom,
    output board_pkg::window_t addr_rom1,
    output board_pkg::window_t addr_work_ram,
    output board_pkg::window_t addr_screen,
    output board_pkg::window_t addr_obj,
    output board_pkg::window_t addr_color,
    output board_pkg::window_t addr_io,
    output board_pkg::window_t addr_sound,
    output board_pkg::window_t addr_extension,
    output board_pkg::window_t addr_priority,
    output board_pkg::window_t addr_roz
);

    import board_pkg::*;

    window_t win_d [NUM_REGIONS];   // next map, from table
    window_t win_q [NUM_REGIONS];   // registered map

    // table lookup, unused regions stay at ff00
    always_comb begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
            win_d[i] = WINDOW_UNUSED;
        end

        case (game)
            GAME_FINALB: begin
                win_d[REGION_ROM]      = 16'h00fc;  // 256k program
                win_d[REGION_WORK_RAM] = 16'h10ff;
                win_d[REGION_COLOR]    = 16'h20ff;  // pcr regs
                win_d[REGION_IO]       = 16'h30ff;
                win_d[REGION_SOUND]    = 16'h32ff;
                win_d[REGION_SCREEN]   = 16'h80f0;  // 80xxxx tilemap ram
                win_d[REGION_OBJ]      = 16'h90ff;
            end

            GAME_DINOREX: begin
                win_d[REGION_ROM]       = 16'h00e0; // 2m program
                win_d[REGION_ROM1]      = 16'h20f0; // data rom above program
                win_d[REGION_IO]        = 16'h30ff;
                win_d[REGION_EXTENSION] = 16'h40ff; // extender ram
                win_d[REGION_COLOR]     = 16'h50ff;
                win_d[REGION_WORK_RAM]  = 16'h60f0; // ram moved high
                win_d[REGION_PRIORITY]  = 16'h70ff;
                win_d[REGION_OBJ]       = 16'h80ff; // obj and screen swapped
                win_d[REGION_SCREEN]    = 16'h90f0;
                win_d[REGION_SOUND]     = 16'ha0ff;
            end

            GAME_LIQUIDK: begin
                win_d[REGION_ROM]      = 16'h00f8;  // 512k program
                win_d[REGION_WORK_RAM] = 16'h10ff;
                win_d[REGION_COLOR]    = 16'h20ff;  // palette ram
                win_d[REGION_IO]       = 16'h30ff;
                win_d[REGION_SOUND]    = 16'h32ff;
                win_d[REGION_SCREEN]   = 16'h80f0;
                win_d[REGION_OBJ]      = 16'h90ff;
                win_d[REGION_PRIORITY] = 16'hb0ff;  // mixer regs
            end

            GAME_GUNFRONT: begin
                win_d[REGION_ROM]      = 16'h00f0;  // 1m decode
                win_d[REGION_WORK_RAM] = 16'h10ff;
                win_d[REGION_COLOR]    = 16'h20ff;
                win_d[REGION_IO]       = 16'h30ff;
                win_d[REGION_SOUND]    = 16'h32ff;
                win_d[REGION_SCREEN]   = 16'h80f0;
                win_d[REGION_OBJ]      = 16'h90ff;
                win_d[REGION_PRIORITY] = 16'hb0ff;
            end

            GAME_GROWL: begin
                win_d[REGION_ROM]       = 16'h00f0;
                win_d[REGION_WORK_RAM]  = 16'h10ff;
                win_d[REGION_COLOR]     = 16'h20ff;
                win_d[REGION_IO]        = 16'h30f0; // 30 to 3f, dsw inputs watchdog
                win_d[REGION_SOUND]     = 16'h40ff; // sound moved up
                win_d[REGION_EXTENSION] = 16'h50ff; // sprite bank and extra inputs
                win_d[REGION_SCREEN]    = 16'h80f0;
                win_d[REGION_OBJ]       = 16'h90ff;
                win_d[REGION_PRIORITY]  = 16'hb0ff;
            end

            GAME_DONDOKOD: begin
                win_d[REGION_ROM]      = 16'h00f8;
                win_d[REGION_WORK_RAM] = 16'h10ff;
                win_d[REGION_COLOR]    = 16'h20ff;
                win_d[REGION_IO]       = 16'h30ff;
                win_d[REGION_SOUND]    = 16'h32ff;
                win_d[REGION_SCREEN]   = 16'h80f0;
                win_d[REGION_OBJ]      = 16'h90ff;
                win_d[REGION_ROZ]      = 16'ha0fe;  // a0 and a1, roz chip ram
                win_d[REGION_PRIORITY] = 16'hb0ff;
            end

            default: begin                          // game_other, empty map
            end
        endcase
    end

    // map registers, cleared to unused in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                win_q[i] <= WINDOW_UNUSED;
            end
        end else begin
            win_q <= win_d;
        end
    end

    assign addr_rom       = win_q[REGION_ROM];
    assign addr_rom1      = win_q[REGION_ROM1];
    assign addr_work_ram  = win_q[REGION_WORK_RAM];
    assign addr_screen    = win_q[REGION_SCREEN];
    assign addr_obj       = win_q[REGION_OBJ];
    assign addr_color     = win_q[REGION_COLOR];
    assign addr_io        = win_q[REGION_IO];
    assign addr_sound     = win_q[REGION_SOUND];
    assign addr_extension = win_q[REGION_EXTENSION];
    assign addr_priority  = win_q[REGION_PRIORITY];
    assign addr_roz       = win_q[REGION_ROZ];

    // every real board has a program rom, only the catch-all leaves it empty
    a_rom_only_unused_for_other: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> ((addr_rom == WINDOW_UNUSED) == ($past(game) == GAME_OTHER))
    ) else $error("addr_rom unused state does not match game");

endmodule

// ==== logic/board_config.sv ====
module board_config (
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::game_t    game,           // board select from the loader

    // feature flags
    output logic                has_360pri,
    output logic                has_260dar,
    output logic                has_110pcr,
    output logic                io_swap,
    output logic                io_tmp,
    output logic                has_190fmc,
    output board_pkg::obj_ext_t obj_ext,

    // cpu address windows
    output board_pkg::window_t  addr_rom,
    output board_pkg::window_t  addr_rom1,
    output board_pkg::window_t  addr_work_ram,
    output board_pkg::window_t  addr_screen,
    output board_pkg::window_t  addr_obj,
    output board_pkg::window_t  addr_color,
    output board_pkg::window_t  addr_io,
    output board_pkg::window_t  addr_sound,
    output board_pkg::window_t  addr_extension,
    output board_pkg::window_t  addr_priority,
    output board_pkg::window_t  addr_roz
);

    // chip presence and io quirks
    board_feature_flags board_feature_flags_i (
        .clk        (clk),
        .rst        (rst),
        .game       (game),
        .has_360pri (has_360pri),
        .has_260dar (has_260dar),
        .has_110pcr (has_110pcr),
        .io_swap    (io_swap),
        .io_tmp     (io_tmp),
        .has_190fmc (has_190fmc),
        .obj_ext    (obj_ext)
    );

    // per region decode windows, same latency as the flags
    board_memory_map board_memory_map_i (
        .clk            (clk),
        .rst            (rst),
        .game           (game),
        .addr_rom       (addr_rom),
        .addr_rom1      (addr_rom1),
        .addr_work_ram  (addr_work_ram),
        .addr_screen    (addr_screen),
        .addr_obj       (addr_obj),
        .addr_color     (addr_color),
        .addr_io        (addr_io),
        .addr_sound     (addr_sound),
        .addr_extension (addr_extension),
        .addr_priority  (addr_priority),
        .addr_roz       (addr_roz)
    );

endmodule

// ==== bench/board_config_tb.sv ====
module board_config_tb;

    import board_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int HOLD_CYCLES    = 4;      // cycles each board stays selected
    localparam int NUM_BOARDS     = 7;
    localparam int RANDOM_CYCLES  = 200;
    localparam int MID_RST_CYCLES = 2;
    localparam int TAIL_CYCLES    = 4;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + NUM_BOARDS * HOLD_CYCLES + RANDOM_CYCLES
                                    + MID_RST_CYCLES + HOLD_CYCLES + TAIL_CYCLES;
    localparam int WATCHDOG_TIME  = (TOTAL_CYCLES + 50) * CLK_PERIOD;   // 50 cycles margin

    localparam game_t BOARD_LIST [NUM_BOARDS] = '{GAME_FINALB, GAME_DINOREX, GAME_LIQUIDK,
        GAME_GUNFRONT, GAME_GROWL, GAME_DONDOKOD, GAME_OTHER};

    // expected state of every output
    typedef struct packed {
        logic                      has_360pri;
        logic                      has_260dar;
        logic                      has_110pcr;
        logic                      io_swap;
        logic                      io_tmp;
        logic                      has_190fmc;
        obj_ext_t                  obj_ext;
        window_t [NUM_REGIONS-1:0] win;         // indexed by region_t
    } expect_t;

    logic     clk;
    logic     rst;
    game_t    game;
    logic     has_360pri, has_260dar, has_110pcr, io_swap, io_tmp, has_190fmc;
    obj_ext_t obj_ext;
    window_t  addr_rom, addr_rom1, addr_work_ram, addr_screen, addr_obj, addr_color;
    window_t  addr_io, addr_sound, addr_extension, addr_priority, addr_roz;

    game_t    sampled_game;                     // game seen by the dut at the last edge
    logic     sampled_rst;
    logic     checking = 1'b0;                  // set after the first rising edge
    int       flag_errors = 0;
    int       window_errors = 0;
    int       checks = 0;

    board_config board_config_i (.*);           // tb names match the dut ports

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // flag and window rows from the board tables
    function automatic expect_t expected_config(input game_t g, input logic in_reset);
        expect_t e;
        e = '0;
        e.win = {NUM_REGIONS{WINDOW_UNUSED}};
        if (in_reset) begin
            return e;                           // all flags low, map empty
        end
        e.has_360pri = 1'b1;                    // default row
        e.has_260dar = 1'b1;
        if (g != GAME_OTHER && g != GAME_DINOREX) begin
            e.win[REGION_WORK_RAM] = 16'h10ff;  // layout shared by the 80xxxx screen boards
            e.win[REGION_COLOR]    = 16'h20ff;
            e.win[REGION_IO]       = 16'h30ff;
            e.win[REGION_SOUND]    = 16'h32ff;
            e.win[REGION_SCREEN]   = 16'h80f0;
            e.win[REGION_OBJ]      = 16'h90ff;
            e.win[REGION_PRIORITY] = 16'hb0ff;
        end
        case (g)
            GAME_FINALB: begin
                e.has_360pri           = 1'b0;
                e.has_260dar           = 1'b0;
                e.has_110pcr           = 1'b1;
                e.win[REGION_ROM]      = 16'h00fc;
                e.win[REGION_PRIORITY] = WINDOW_UNUSED;   // no mixer on this board
            end
            GAME_DINOREX: begin
                e.obj_ext               = OBJ_EXT_DINO;
                e.win[REGION_ROM]       = 16'h00e0;
                e.win[REGION_ROM1]      = 16'h20f0;
                e.win[REGION_IO]        = 16'h30ff;
                e.win[REGION_EXTENSION] = 16'h40ff;
                e.win[REGION_COLOR]     = 16'h50ff;
                e.win[REGION_WORK_RAM]  = 16'h60f0;
                e.win[REGION_PRIORITY]  = 16'h70ff;
                e.win[REGION_OBJ]       = 16'h80ff;
                e.win[REGION_SCREEN]    = 16'h90f0;
                e.win[REGION_SOUND]     = 16'ha0ff;
            end
            GAME_LIQUIDK: begin
                e.win[REGION_ROM] = 16'h00f8;
            end
            GAME_GUNFRONT: begin
                e.io_swap         = 1'b1;
                e.win[REGION_ROM] = 16'h00f0;
            end
            GAME_GROWL: begin
                e.io_tmp                = 1'b1;
                e.has_190fmc            = 1'b1;
                e.win[REGION_ROM]       = 16'h00f0;
                e.win[REGION_IO]        = 16'h30f0;
                e.win[REGION_SOUND]     = 16'h40ff;
                e.win[REGION_EXTENSION] = 16'h50ff;
            end
            GAME_DONDOKOD: begin
                e.win[REGION_ROM] = 16'h00f8;
                e.win[REGION_ROZ] = 16'ha0fe;   // only board with a roz layer
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            flag_errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ext(input string name, input obj_ext_t got, input obj_ext_t exp);
        checks++;
        if (got !== exp) begin
            flag_errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_window(input string name, input window_t got, input window_t exp);
        checks++;
        if (got !== exp) begin
            window_errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_bit("has_360pri", has_360pri, e.has_360pri);
        check_bit("has_260dar", has_260dar, e.has_260dar);
        check_bit("has_110pcr", has_110pcr, e.has_110pcr);
        check_bit("io_swap", io_swap, e.io_swap);
        check_bit("io_tmp", io_tmp, e.io_tmp);
        check_bit("has_190fmc", has_190fmc, e.has_190fmc);
        check_ext("obj_ext", obj_ext, e.obj_ext);
        check_window("addr_rom", addr_rom, e.win[REGION_ROM]);
        check_window("addr_rom1", addr_rom1, e.win[REGION_ROM1]);
        check_window("addr_work_ram", addr_work_ram, e.win[REGION_WORK_RAM]);
        check_window("addr_screen", addr_screen, e.win[REGION_SCREEN]);
        check_window("addr_obj", addr_obj, e.win[REGION_OBJ]);
        check_window("addr_color", addr_color, e.win[REGION_COLOR]);
        check_window("addr_io", addr_io, e.win[REGION_IO]);
        check_window("addr_sound", addr_sound, e.win[REGION_SOUND]);
        check_window("addr_extension", addr_extension, e.win[REGION_EXTENSION]);
        check_window("addr_priority", addr_priority, e.win[REGION_PRIORITY]);
        check_window("addr_roz", addr_roz, e.win[REGION_ROZ]);
    endtask

    // select a board at a falling edge and keep it for some cycles
    task automatic hold_board(input game_t g, input int cycles);
        game = g;
        repeat (cycles) @(negedge clk);
    endtask

    // what the dut registered at this edge
    always @(posedge clk) begin
        sampled_game <= game;
        sampled_rst  <= rst;
        checking     <= 1'b1;
    end

    // outputs settled since the rising edge
    always @(negedge clk) begin
        if (checking) begin
            compare_outputs(expected_config(sampled_game, sampled_rst));
        end
    end

    initial begin
        void'($urandom(32'h5812c978));
        rst  = 1'b1;
        game = GAME_DINOREX;                    // reset has to win over a real board
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_BOARDS; i++) begin
            hold_board(BOARD_LIST[i], HOLD_CYCLES);
        end
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            hold_board(game_t'($urandom_range(6, 0)), 1);   // new board every cycle
        end
        rst = 1'b1;                             // mid-run reset
        hold_board(GAME_GROWL, MID_RST_CYCLES);
        rst = 1'b0;
        hold_board(GAME_GROWL, HOLD_CYCLES);    // table values back
        hold_board(GAME_OTHER, TAIL_CYCLES);
        @(posedge clk);                         // last compare done at the edge before
        $display("checks %0d, flag errors %0d, window errors %0d",
                 checks, flag_errors, window_errors);
        if (flag_errors == 0 && window_errors == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, stimulus never finished",
                 WATCHDOG_TIME);
        $display("checks %0d, flag errors %0d, window errors %0d",
                 checks, flag_errors, window_errors);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/board_pkg.sv
logic/board_feature_flags.sv
logic/board_memory_map.sv
logic/board_config.sv
bench/board_config_tb.sv

// ==== Makefile ====
# Verilator build and run for the board configuration unit

VERILATOR ?= verilator
TOP       ?= board_config_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in the output"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
